// ==== logic/lcd_hex_pkg.sv ====
`default_nettype none

package lcd_hex_pkg;

  // Bus and value widths
  typedef logic [7:0]  lcd_byte_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [3:0]  col_idx_t;
  typedef logic [63:0] row_value_t;
  typedef logic [15:0] row_mask_t;

  // Sequencer FSM
  typedef enum logic [2:0] {
    SEQ_INIT_CMD,
    SEQ_WAIT,
    SEQ_READY,
    SEQ_SET_ROW1,
    SEQ_ROW1_CHARS,
    SEQ_SET_ROW2,
    SEQ_ROW2_CHARS
  } seq_state_t;

  // Bus cycle engine FSM
  typedef enum logic [2:0] {
    BUS_IDLE,
    BUS_SETUP,
    BUS_E_HIGH,
    BUS_HOLD,
    BUS_POLL_SETUP,
    BUS_POLL_HIGH,
    BUS_POLL_CHECK
  } bus_state_t;

  // Panel instructions
  localparam lcd_byte_t CMD_FUNCTION_SET = 8'h38;  // 8-bit bus, two lines, 5x8 font
  localparam lcd_byte_t CMD_DISPLAY_ON   = 8'h0e;
  localparam lcd_byte_t CMD_ENTRY_MODE   = 8'h06;
  localparam lcd_byte_t CMD_CURSOR_LEFT  = 8'h10;
  localparam lcd_byte_t CMD_ROW1_ADDR    = 8'h80;
  localparam lcd_byte_t CMD_ROW2_ADDR    = 8'hc0;

  // Character codes
  localparam lcd_byte_t CHAR_BLANK       = 8'h20;

endpackage

`default_nettype wire

// ==== logic/hex_char_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module hex_char_select import lcd_hex_pkg::*; (
  input  row_value_t row_value,
  input  row_mask_t  row_mask,
  input  col_idx_t   col,
  output lcd_byte_t  char_code
);

  localparam lcd_byte_t ASCII_ZERO    = 8'h30;
  localparam lcd_byte_t ASCII_LOWER_A = 8'h61;

  // Column 0 is the top nibble, so index from the left
  col_idx_t  nib_idx;
  nibble_t   digit;
  logic      shown;
  lcd_byte_t hex_code;

  assign nib_idx = ~col;
  assign digit   = row_value[{nib_idx, 2'b00} +: 4];
  assign shown   = row_mask[nib_idx];

  // Digits 0-9 then lower case a-f
  always_comb begin
    if (digit < 4'd10) begin
      hex_code = ASCII_ZERO + {4'h0, digit};
    end else begin
      hex_code = ASCII_LOWER_A + {4'h0, digit} - 8'd10;
    end
  end

  assign char_code = shown ? hex_code : CHAR_BLANK;

endmodule

`default_nettype wire

// ==== logic/lcd_bus_cycle.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_bus_cycle import lcd_hex_pkg::*; #(
  parameter int E_PULSE_CYCLES = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_start,
  input  logic      cmd_poll_only,
  input  logic      cmd_rs,
  input  lcd_byte_t cmd_data,
  input  lcd_byte_t db_in,
  output logic      cmd_done,
  output logic      rs,
  output logic      rw,
  output logic      e,
  output logic      db_oe,
  output lcd_byte_t db_out
);

  localparam int CNT_W = (E_PULSE_CYCLES > 1) ? $clog2(E_PULSE_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(E_PULSE_CYCLES - 1);

  bus_state_t       state;
  logic [CNT_W-1:0] pulse_cnt;
  logic             pulse_last;
  logic             panel_busy;
  lcd_byte_t        data_q;
  logic             rs_q;

  assign pulse_last = (pulse_cnt == CNT_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= BUS_IDLE;
      pulse_cnt  <= '0;
      panel_busy <= 1'b1;
    end else begin
      case (state)
        BUS_IDLE: begin
          if (cmd_start) begin
            state <= cmd_poll_only ? BUS_POLL_SETUP : BUS_SETUP;
          end
        end
        BUS_SETUP: begin
          pulse_cnt <= '0;
          state     <= BUS_E_HIGH;
        end
        BUS_E_HIGH: begin
          if (pulse_last) begin
            state <= BUS_HOLD;
          end else begin
            pulse_cnt <= pulse_cnt + 1'b1;
          end
        end
        BUS_HOLD: begin
          state <= BUS_POLL_SETUP;
        end
        BUS_POLL_SETUP: begin
          pulse_cnt <= '0;
          state     <= BUS_POLL_HIGH;
        end
        BUS_POLL_HIGH: begin
          // Busy flag is sampled on the last cycle of the read strobe
          if (pulse_last) begin
            panel_busy <= db_in[7];
            state      <= BUS_POLL_CHECK;
          end else begin
            pulse_cnt <= pulse_cnt + 1'b1;
          end
        end
        BUS_POLL_CHECK: begin
          state <= panel_busy ? BUS_POLL_SETUP : BUS_IDLE;
        end
        default: begin
          state <= BUS_IDLE;
        end
      endcase
    end
  end

  // Command byte held from setup through hold
  always_ff @(posedge clk) begin
    if (state == BUS_IDLE && cmd_start) begin
      data_q <= cmd_data;
      rs_q   <= cmd_rs;
    end
  end

  // Write phase drives the bus, everything else is a read of the status register
  assign db_oe    = (state == BUS_SETUP) || (state == BUS_E_HIGH) || (state == BUS_HOLD);
  assign rw       = ~db_oe;
  assign rs       = db_oe & rs_q;
  assign e        = (state == BUS_E_HIGH) || (state == BUS_POLL_HIGH);
  assign db_out   = data_q;
  assign cmd_done = (state == BUS_POLL_CHECK) && !panel_busy;

endmodule

`default_nettype wire

// ==== logic/lcd_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_sequencer import lcd_hex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  row_value_t f1,
  input  row_value_t f2,
  input  row_mask_t  m1,
  input  row_mask_t  m2,
  input  lcd_byte_t  char_code,
  input  logic       cmd_done,
  output logic       busy,
  output row_value_t row_value,
  output row_mask_t  row_mask,
  output col_idx_t   col,
  output logic       cmd_start,
  output logic       cmd_poll_only,
  output logic       cmd_rs,
  output lcd_byte_t  cmd_data
);

  seq_state_t state;
  seq_state_t issued_state;
  logic       issue;
  logic [2:0] init_idx;
  lcd_byte_t  init_byte;

  row_value_t row1_value_q;
  row_value_t row2_value_q;
  row_mask_t  row1_mask_q;
  row_mask_t  row2_mask_q;

  // Issue states last one cycle with cmd_start high, then hand over to WAIT.
  // Only the first command after reset takes an extra cycle to arm issue.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= SEQ_INIT_CMD;
      issued_state <= SEQ_INIT_CMD;
      issue        <= 1'b0;
      init_idx     <= 3'd0;
      col          <= '0;
      busy         <= 1'b1;
    end else begin
      case (state)
        SEQ_INIT_CMD, SEQ_SET_ROW1, SEQ_ROW1_CHARS, SEQ_SET_ROW2, SEQ_ROW2_CHARS: begin
          if (issue) begin
            issue        <= 1'b0;
            issued_state <= state;
            state        <= SEQ_WAIT;
          end else begin
            issue <= 1'b1;
          end
        end
        SEQ_WAIT: begin
          if (cmd_done) begin
            case (issued_state)
              SEQ_INIT_CMD: begin
                if (init_idx == 3'd4) begin
                  busy  <= 1'b0;
                  state <= SEQ_READY;
                end else begin
                  init_idx <= init_idx + 3'd1;
                  issue    <= 1'b1;
                  state    <= SEQ_INIT_CMD;
                end
              end
              SEQ_SET_ROW1: begin
                issue <= 1'b1;
                state <= SEQ_ROW1_CHARS;
              end
              SEQ_ROW1_CHARS: begin
                issue <= 1'b1;
                col   <= col + 4'd1;
                if (col == 4'd15) begin
                  state <= SEQ_SET_ROW2;
                end else begin
                  state <= SEQ_ROW1_CHARS;
                end
              end
              SEQ_SET_ROW2: begin
                issue <= 1'b1;
                state <= SEQ_ROW2_CHARS;
              end
              default: begin
                // Row 2 ends when col wraps back to 0
                col <= col + 4'd1;
                if (col == 4'd15) begin
                  busy  <= 1'b0;
                  state <= SEQ_READY;
                end else begin
                  issue <= 1'b1;
                  state <= SEQ_ROW2_CHARS;
                end
              end
            endcase
          end
        end
        SEQ_READY: begin
          if (go) begin
            busy  <= 1'b1;
            col   <= '0;
            issue <= 1'b1;
            state <= SEQ_SET_ROW1;
          end
        end
        default: begin
          state <= SEQ_READY;
        end
      endcase
    end
  end

  // Snapshot of the screen contents for one refresh
  always_ff @(posedge clk) begin
    if (state == SEQ_READY && go) begin
      row1_value_q <= f1;
      row2_value_q <= f2;
      row1_mask_q  <= m1;
      row2_mask_q  <= m2;
    end
  end

  // Index 0 is the poll-only start and its byte never reaches the bus
  always_comb begin
    case (init_idx)
      3'd2:    init_byte = CMD_DISPLAY_ON;
      3'd3:    init_byte = CMD_ENTRY_MODE;
      3'd4:    init_byte = CMD_CURSOR_LEFT;
      default: init_byte = CMD_FUNCTION_SET;
    endcase
  end

  always_comb begin
    case (state)
      SEQ_INIT_CMD: cmd_data = init_byte;
      SEQ_SET_ROW1: cmd_data = CMD_ROW1_ADDR;
      SEQ_SET_ROW2: cmd_data = CMD_ROW2_ADDR;
      default:      cmd_data = char_code;
    endcase
  end

  assign cmd_start     = issue && (state != SEQ_WAIT) && (state != SEQ_READY);
  assign cmd_poll_only = (state == SEQ_INIT_CMD) && (init_idx == 3'd0);
  assign cmd_rs        = (state == SEQ_ROW1_CHARS) || (state == SEQ_ROW2_CHARS);

  assign row_value = (state == SEQ_ROW2_CHARS) ? row2_value_q : row1_value_q;
  assign row_mask  = (state == SEQ_ROW2_CHARS) ? row2_mask_q  : row1_mask_q;

endmodule

`default_nettype wire

// ==== logic/lcd_hex_display.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_hex_display import lcd_hex_pkg::*; #(
  parameter int E_PULSE_CYCLES = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  row_value_t f1,
  input  row_value_t f2,
  input  row_mask_t  m1,
  input  row_mask_t  m2,
  input  lcd_byte_t  db_in,
  output logic       busy,
  output logic       rs,
  output logic       rw,
  output logic       e,
  output logic       db_oe,
  output lcd_byte_t  db_out
);

  row_value_t row_value;
  row_mask_t  row_mask;
  col_idx_t   col;
  lcd_byte_t  char_code;
  logic       cmd_start;
  logic       cmd_poll_only;
  logic       cmd_rs;
  lcd_byte_t  cmd_data;
  logic       cmd_done;

  lcd_sequencer u_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .go            (go),
    .f1            (f1),
    .f2            (f2),
    .m1            (m1),
    .m2            (m2),
    .char_code     (char_code),
    .cmd_done      (cmd_done),
    .busy          (busy),
    .row_value     (row_value),
    .row_mask      (row_mask),
    .col           (col),
    .cmd_start     (cmd_start),
    .cmd_poll_only (cmd_poll_only),
    .cmd_rs        (cmd_rs),
    .cmd_data      (cmd_data)
  );

  hex_char_select u_char_select (
    .row_value (row_value),
    .row_mask  (row_mask),
    .col       (col),
    .char_code (char_code)
  );

  lcd_bus_cycle #(
    .E_PULSE_CYCLES (E_PULSE_CYCLES)
  ) u_bus_cycle (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_start     (cmd_start),
    .cmd_poll_only (cmd_poll_only),
    .cmd_rs        (cmd_rs),
    .cmd_data      (cmd_data),
    .db_in         (db_in),
    .cmd_done      (cmd_done),
    .rs            (rs),
    .rw            (rw),
    .e             (e),
    .db_oe         (db_oe),
    .db_out        (db_out)
  );

endmodule

`default_nettype wire

// ==== sim/lcd_panel_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_panel_model import lcd_hex_pkg::*; #(
  parameter int E_PULSE_CYCLES = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rs,
  input  logic       rw,
  input  logic       e,
  input  logic       db_oe,
  input  lcd_byte_t  db_out,
  input  logic [2:0] busy_len,
  output lcd_byte_t  db_in
);

  lcd_byte_t  ddram [0:127];
  lcd_byte_t  instr_log [0:255];
  int         instr_count = 0;
  int         proto_errors = 0;
  int         busy_cnt = 3;
  int         high_cnt = 0;
  logic       e_q = 1'b0;
  logic [6:0] addr = '0;
  logic       write_rise;
  logic       write_fall;

  // Status read returns the busy flag and the address counter
  assign db_in      = {busy_cnt != 0, addr};
  assign write_rise = e && !e_q && !rw;
  assign write_fall = e_q && !e && !rw;

  always @(posedge clk) begin
    assert (!(db_oe && rw)) else begin
      proto_errors++;
      $display("protocol: data bus driven during a read cycle");
    end
    if (!rst_n) begin
      // Power-up contents that no hex digit or blank can match
      for (int i = 0; i < 128; i++) begin
        ddram[7'(i)] <= {1'b1, 7'(i)};
      end
      instr_count <= 0;
      busy_cnt    <= 3;
      high_cnt    <= 0;
      e_q         <= 1'b0;
      addr        <= '0;
    end else begin
      e_q <= e;
      if (e) begin
        high_cnt <= e_q ? high_cnt + 1 : 1;
      end
      if (write_rise) begin
        assert (busy_cnt == 0) else begin
          proto_errors++;
          $display("protocol: write strobe started while the panel was busy");
        end
      end
      if (e_q && !e) begin
        assert (high_cnt == E_PULSE_CYCLES) else begin
          proto_errors++;
          $display("error protocol: e width expected %0d, actual %0d",
                   E_PULSE_CYCLES, high_cnt);
        end
      end
      if (write_fall) begin
        busy_cnt <= int'(busy_len);
        if (rs) begin
          ddram[addr] <= db_out;
          addr        <= addr + 7'd1;
        end else begin
          instr_log[instr_count[7:0]] <= db_out;
          instr_count                 <= instr_count + 1;
          if (db_out[7]) begin
            addr <= db_out[6:0];
          end else if (db_out[7:3] == 5'b00010) begin
            // Cursor shift moves the address counter
            addr <= db_out[2] ? addr + 7'd1 : addr - 7'd1;
          end
        end
      end else if (busy_cnt != 0) begin
        busy_cnt <= busy_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_lcd_hex_display.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_hex_display
  import lcd_hex_pkg::*;
();

  localparam int          E_PULSE    = 4;
  localparam int          WAIT_LIMIT = 5000;
  localparam logic [19:0] LFSR_SEED  = 20'd82256;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        go;
  row_value_t  f1;
  row_value_t  f2;
  row_mask_t   m1;
  row_mask_t   m2;
  lcd_byte_t   db_in;
  lcd_byte_t   db_out;
  logic        busy;
  logic        rs;
  logic        rw;
  logic        e;
  logic        db_oe;
  logic [2:0]  busy_len = 3'd0;
  logic [19:0] stim_lfsr = LFSR_SEED;
  logic [19:0] busy_lfsr = LFSR_SEED;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          test_start_errors = 0;

  always #2 clk = ~clk;

  lcd_hex_display #(
    .E_PULSE_CYCLES (E_PULSE)
  ) u_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .go     (go),
    .f1     (f1),
    .f2     (f2),
    .m1     (m1),
    .m2     (m2),
    .db_in  (db_in),
    .busy   (busy),
    .rs     (rs),
    .rw     (rw),
    .e      (e),
    .db_oe  (db_oe),
    .db_out (db_out)
  );

  lcd_panel_model #(
    .E_PULSE_CYCLES (E_PULSE)
  ) u_panel (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs       (rs),
    .rw       (rw),
    .e        (e),
    .db_oe    (db_oe),
    .db_out   (db_out),
    .busy_len (busy_len),
    .db_in    (db_in)
  );

  // Fibonacci LFSR x^20 + x^17 + 1, the bit shifted in is the one taken
  function automatic logic [19:0] lfsr_step(logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[62:0], stim_lfsr[0]};
    end
  endtask

  // Panel busy time after each write, 0 to 7 clocks
  always @(negedge clk) begin
    logic [2:0] len;
    for (int i = 0; i < 3; i++) begin
      busy_lfsr = lfsr_step(busy_lfsr);
      len = {len[1:0], busy_lfsr[0]};
    end
    busy_len <= len;
  end

  // Column 0 is the top nibble and mask bit 15
  function automatic lcd_byte_t expected_char(row_value_t v, row_mask_t m, int c);
    string     digits = "0123456789abcdef";
    nibble_t   d;
    row_mask_t shifted;
    d = nibble_t'(v >> (4 * (15 - c)));
    shifted = m >> (15 - c);
    if (!shifted[0]) begin
      return 8'h20;
    end
    return digits[d];
  endfunction

  task automatic check_byte(input string name, input lcd_byte_t exp, input lcd_byte_t act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s: %0d errors", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  task automatic wait_busy(input logic level, input string name);
    int n;
    n = 0;
    while (busy !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy !== level) begin
      errors++;
      $display("%s: busy did not reach %0d within %0d cycles", name, level, WAIT_LIMIT);
    end
  endtask

  task automatic pulse_go(input row_value_t v1, input row_value_t v2,
                          input row_mask_t k1, input row_mask_t k2);
    f1 = v1;
    f2 = v2;
    m1 = k1;
    m2 = k2;
    go = 1'b1;
    @(negedge clk);
    go = 1'b0;
  endtask

  task automatic check_screen(input string name, input row_value_t v1, input row_value_t v2,
                              input row_mask_t k1, input row_mask_t k2);
    for (int c = 0; c < 16; c++) begin
      check_byte($sformatf("%s row 1 col %0d", name, c), expected_char(v1, k1, c),
                 u_panel.ddram[7'(c)]);
      check_byte($sformatf("%s row 2 col %0d", name, c), expected_char(v2, k2, c),
                 u_panel.ddram[7'(8'h40 + c)]);
    end
  endtask

  initial begin
    row_value_t  v1;
    row_value_t  v2;
    row_mask_t   k1;
    row_mask_t   k2;
    logic [63:0] r;
    int          count0;
    rst_n = 1'b0;
    go    = 1'b0;
    f1    = '0;
    f2    = '0;
    m1    = '0;
    m2    = '0;

    repeat (4) begin
      @(negedge clk);
      check_byte("reset_state", 8'h03, {4'h0, e, db_oe, rw, busy});
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_byte("reset_state", 8'h03, {4'h0, e, db_oe, rw, busy});
    end_test("reset_state");

    wait_busy(1'b0, "init");
    check_byte("init count", 8'd4, 8'(u_panel.instr_count));
    check_byte("init cmd 0", 8'h38, u_panel.instr_log[8'd0]);
    check_byte("init cmd 1", 8'h0e, u_panel.instr_log[8'd1]);
    check_byte("init cmd 2", 8'h06, u_panel.instr_log[8'd2]);
    check_byte("init cmd 3", 8'h10, u_panel.instr_log[8'd3]);
    end_test("init");

    count0 = u_panel.instr_count;
    v1 = 64'h0123_4567_89ab_cdef;
    v2 = 64'hfedc_ba98_7654_3210;
    pulse_go(v1, v2, 16'hf0f5, 16'h5aff);
    wait_busy(1'b0, "content");
    check_screen("content", v1, v2, 16'hf0f5, 16'h5aff);
    check_byte("content row 1 addr", 8'h80, u_panel.instr_log[8'(count0)]);
    check_byte("content row 2 addr", 8'hc0, u_panel.instr_log[8'(count0 + 1)]);
    end_test("content");

    // Inputs move after the capture and a second go lands mid-refresh
    count0 = u_panel.instr_count;
    v1 = 64'hdead_beef_0bad_f00d;
    v2 = 64'h1357_9bdf_2468_ace0;
    pulse_go(v1, v2, 16'hffff, 16'h0ff0);
    f1 = ~v1;
    f2 = ~v2;
    m1 = 16'h1234;
    m2 = 16'hffff;
    repeat (100) @(negedge clk);
    check_byte("capture busy", 8'h01, {7'h0, busy});
    pulse_go(64'h5555_aaaa_5555_aaaa, 64'h0, 16'h00ff, 16'hff00);
    wait_busy(1'b0, "capture");
    check_screen("capture", v1, v2, 16'hffff, 16'h0ff0);
    repeat (40) @(negedge clk);
    check_byte("capture count", 8'(count0 + 2), 8'(u_panel.instr_count));
    check_byte("capture idle", 8'h00, {7'h0, busy});
    end_test("capture");

    for (int i = 0; i < 8; i++) begin
      draw_bits(64, r);
      v1 = r;
      draw_bits(64, r);
      v2 = r;
      draw_bits(16, r);
      k1 = row_mask_t'(r);
      draw_bits(16, r);
      k2 = row_mask_t'(r);
      if (i == 0) begin
        k1 = '0;
        k2 = '0;
      end else if (i == 1) begin
        k1 = '1;
        k2 = '1;
      end
      pulse_go(v1, v2, k1, k2);
      wait_busy(1'b0, "random");
      check_screen($sformatf("random %0d", i), v1, v2, k1, k2);
    end
    end_test("random");

    checks++;
    assert (u_panel.proto_errors == 0) else begin
      errors++;
      $display("error protocol: expected 0 violations, actual %0d", u_panel.proto_errors);
    end
    end_test("protocol");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== lcd_hex_display.f ====
logic/lcd_hex_pkg.sv
logic/hex_char_select.sv
logic/lcd_bus_cycle.sv
logic/lcd_sequencer.sv
logic/lcd_hex_display.sv
sim/lcd_panel_model.sv
sim/tb_lcd_hex_display.sv

// ==== Makefile ====
TOP := tb_lcd_hex_display

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f lcd_hex_display.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
